/* rtl/ooo_pkg.sv */
/* shared types for the one-lane rename and writeback slice
   physical register and reorder-buffer id widths come from module parameters */
package ooo_pkg;

    // fixed by the RV32I ISA
    localparam int NUM_ARCH_REGS = 32;
    localparam int XLEN = 32;
    localparam int IMM_W = 12;
    // shift amount field of a 32-bit word
    localparam int SHAMT_W = 5;

    // architectural register number
    typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_reg_t;

    // register value
    typedef logic [XLEN-1:0] word_t;

    // raw i-type immediate, sign-extended at execute
    typedef logic [IMM_W-1:0] imm_t;

    // integer ops handled by the alu pipe
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        // rs1 plus sign-extended imm
        ALU_ADDI = 3'd5,
        // rs1 shifted by low bits of rs2
        ALU_SLL  = 3'd6
    } alu_op_t;

    // incoming instruction, already decoded
    typedef struct packed {
        alu_op_t   op;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        imm_t      imm;
    } inst_t;

    // sign extension of the 12-bit immediate
    function automatic word_t sext_imm(imm_t imm);
        return {{(XLEN - IMM_W){imm[IMM_W-1]}}, imm};
    endfunction

endpackage

/* rtl/rename_stage.sv */
`timescale 1ns/1ns
/* single lane; completions arrive in order so the old mapping is freed at writeback
   never refuses an instruction, sender credits keep the free list from running dry */
module rename_stage #(
    parameter int PHYS_REGS = 64,
    parameter int ROB_DEPTH = 8
) (
    clk,
    rst,
    inst_valid,
    inst,
    cdb,
    rop,
    ren_we,
    ren_prd,
    ren_rob_id,
    credit_return
);
    import ooo_pkg::*;

    localparam int PRW = $clog2(PHYS_REGS);
    localparam int RIW = $clog2(ROB_DEPTH);
    // every register above the reset identity map starts free
    localparam int FL_DEPTH = PHYS_REGS - NUM_ARCH_REGS;
    localparam int FLW = $clog2(FL_DEPTH);
    localparam int FCW = $clog2(FL_DEPTH + 1);

    typedef logic [PRW-1:0] preg_t;
    typedef logic [RIW-1:0] rob_id_t;
    typedef logic [FLW-1:0] fl_ptr_t;
    typedef logic [FCW-1:0] fl_count_t;

    typedef struct packed {
        logic      valid;
        alu_op_t   op;
        imm_t      imm;
        preg_t     prd;
        preg_t     prs1;
        preg_t     prs2;
        preg_t     old_prd;
        arch_reg_t arch_rd;
        rob_id_t   rob_id;
    } renamed_op_t;

    typedef struct packed {
        logic      valid;
        preg_t     prd;
        preg_t     old_prd;
        arch_reg_t arch_rd;
        rob_id_t   rob_id;
        word_t     value;
    } cdb_t;

    input  logic        clk;
    input  logic        rst;
    input  logic        inst_valid;
    input  inst_t       inst;
    input  cdb_t        cdb;
    output renamed_op_t rop;
    output logic        ren_we;
    output preg_t       ren_prd;
    output rob_id_t     ren_rob_id;
    output logic        credit_return;

    // register alias table, arch to phys
    preg_t     rat [NUM_ARCH_REGS];
    // free list as a circular queue
    preg_t     fl_mem [FL_DEPTH];
    fl_ptr_t   fl_head;
    fl_ptr_t   fl_tail;
    fl_count_t fl_count;
    rob_id_t   rob_ctr;
    logic      fl_pop;
    logic      fl_push;
    preg_t     new_prd;

    function automatic fl_ptr_t fl_next(fl_ptr_t p);
        return (p == fl_ptr_t'(FL_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // x0 stays on phys 0, no allocation
    assign fl_pop  = inst_valid && (inst.rd != '0);
    // old mapping of a nonzero rd goes back on completion
    assign fl_push = cdb.valid && (cdb.arch_rd != '0);
    assign new_prd = fl_pop ? fl_mem[fl_head] : '0;

    // rename write marks the new register pending at the same edge
    assign ren_we     = fl_pop;
    assign ren_prd    = new_prd;
    assign ren_rob_id = rob_ctr;
    // one credit per completion, x0 writes included
    assign credit_return = cdb.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                rat[i] <= preg_t'(i);
            end
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_mem[i] <= preg_t'(NUM_ARCH_REGS + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= fl_count_t'(FL_DEPTH);
            rob_ctr  <= '0;
        end else begin
            if (fl_pop) begin
                rat[inst.rd] <= new_prd;
                fl_head      <= fl_next(fl_head);
            end
            if (fl_push) begin
                fl_mem[fl_tail] <= cdb.old_prd;
                fl_tail         <= fl_next(fl_tail);
            end
            fl_count <= fl_count + fl_count_t'(fl_push) - fl_count_t'(fl_pop);
            // every instruction takes an id, wraps at ROB_DEPTH
            if (inst_valid) begin
                rob_ctr <= (rob_ctr == rob_id_t'(ROB_DEPTH - 1)) ? '0 : rob_ctr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // sources see the table before this instruction's own update
        rop.op      <= inst.op;
        rop.imm     <= inst.imm;
        rop.prd     <= new_prd;
        rop.prs1    <= rat[inst.rs1];
        rop.prs2    <= rat[inst.rs2];
        rop.old_prd <= rat[inst.rd];
        rop.arch_rd <= inst.rd;
        rop.rob_id  <= rob_ctr;
        if (rst) begin
            rop.valid <= 1'b0;
        end else begin
            rop.valid <= inst_valid;
        end
    end

endmodule

/* rtl/phys_reg_file.sv */
`timescale 1ns/1ns
/* one rename write port, one cdb write port, two combinational read ports
   phys register 0 is never written and always reads as zero */
module phys_reg_file #(
    parameter int PHYS_REGS = 64,
    parameter int ROB_DEPTH = 8
) (
    clk,
    rst,
    ren_we,
    ren_prd,
    ren_rob_id,
    cdb,
    rd_req,
    rd_data
);
    import ooo_pkg::*;

    localparam int PRW = $clog2(PHYS_REGS);
    localparam int RIW = $clog2(ROB_DEPTH);

    typedef logic [PRW-1:0] preg_t;
    typedef logic [RIW-1:0] rob_id_t;

    typedef struct packed {
        word_t   value;
        logic    pending;
        rob_id_t rob_id;
    } phys_entry_t;

    typedef struct packed {
        logic      valid;
        preg_t     prd;
        preg_t     old_prd;
        arch_reg_t arch_rd;
        rob_id_t   rob_id;
        word_t     value;
    } cdb_t;

    typedef struct packed {
        preg_t prs1;
        preg_t prs2;
    } rd_req_t;

    input  logic              clk;
    input  logic              rst;
    input  logic              ren_we;
    input  preg_t             ren_prd;
    input  rob_id_t           ren_rob_id;
    input  cdb_t              cdb;
    input  rd_req_t           rd_req;
    output phys_entry_t [1:0] rd_data;

    phys_entry_t regs [PHYS_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // result arrives, dependency resolved
            if (cdb.valid && (cdb.prd != '0)) begin
                regs[cdb.prd].value   <= cdb.value;
                regs[cdb.prd].pending <= 1'b0;
            end
            // newer producer claims the entry, wins over a same-cycle cdb hit
            if (ren_we && (ren_prd != '0)) begin
                regs[ren_prd].pending <= 1'b1;
                regs[ren_prd].rob_id  <= ren_rob_id;
            end
        end
    end

    // index 0 is rs1, index 1 is rs2
    always_comb begin
        rd_data[0] = (rd_req.prs1 == '0) ? '0 : regs[rd_req.prs1];
        rd_data[1] = (rd_req.prs2 == '0) ? '0 : regs[rd_req.prs2];
    end

endmodule

/* rtl/alu_pipe.sv */
`timescale 1ns/1ns
/* operands read once here with bypass from this stage's own cdb output
   result registered onto the cdb, x0 results still broadcast with prd zero */
module alu_pipe #(
    parameter int PHYS_REGS = 64,
    parameter int ROB_DEPTH = 8
) (
    clk,
    rst,
    rop,
    rd_req,
    rd_data,
    cdb
);
    import ooo_pkg::*;

    localparam int PRW = $clog2(PHYS_REGS);
    localparam int RIW = $clog2(ROB_DEPTH);

    typedef logic [PRW-1:0] preg_t;
    typedef logic [RIW-1:0] rob_id_t;

    typedef struct packed {
        word_t   value;
        logic    pending;
        rob_id_t rob_id;
    } phys_entry_t;

    typedef struct packed {
        logic      valid;
        alu_op_t   op;
        imm_t      imm;
        preg_t     prd;
        preg_t     prs1;
        preg_t     prs2;
        preg_t     old_prd;
        arch_reg_t arch_rd;
        rob_id_t   rob_id;
    } renamed_op_t;

    typedef struct packed {
        logic      valid;
        preg_t     prd;
        preg_t     old_prd;
        arch_reg_t arch_rd;
        rob_id_t   rob_id;
        word_t     value;
    } cdb_t;

    typedef struct packed {
        preg_t prs1;
        preg_t prs2;
    } rd_req_t;

    input  logic              clk;
    input  logic              rst;
    input  renamed_op_t       rop;
    output rd_req_t           rd_req;
    input  phys_entry_t [1:0] rd_data;
    output cdb_t              cdb;

    logic  byp1;
    logic  byp2;
    word_t src1;
    word_t src2;
    word_t result;

    assign rd_req.prs1 = rop.prs1;
    assign rd_req.prs2 = rop.prs2;

    // producer one ahead is on the cdb now, its file write lands at the next edge
    assign byp1 = cdb.valid && (cdb.prd != '0) && (cdb.prd == rop.prs1);
    assign byp2 = cdb.valid && (cdb.prd != '0) && (cdb.prd == rop.prs2);
    assign src1 = byp1 ? cdb.value : rd_data[0].value;
    assign src2 = byp2 ? cdb.value : rd_data[1].value;

    always_comb begin
        case (rop.op)
            ALU_ADD:  result = src1 + src2;
            ALU_SUB:  result = src1 - src2;
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_ADDI: result = src1 + sext_imm(rop.imm);
            // upper bits of rs2 ignored
            ALU_SLL:  result = src1 << src2[SHAMT_W-1:0];
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        cdb.prd     <= rop.prd;
        cdb.old_prd <= rop.old_prd;
        cdb.arch_rd <= rop.arch_rd;
        cdb.rob_id  <= rop.rob_id;
        cdb.value   <= result;
        if (rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= rop.valid;
        end
    end

endmodule

/* rtl/rename_core_top.sv */
`timescale 1ns/1ns
/* sender starts with PHYS_REGS minus 32 credits, one per instruction, x0 included
   completion comes out two cycles after the input edge, in order */
module rename_core_top #(
    parameter int PHYS_REGS = 64,
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         inst_valid,
    input  ooo_pkg::inst_t               inst,
    output logic                         credit_return,
    output logic                         wb_valid,
    output ooo_pkg::arch_reg_t           wb_arch_rd,
    output logic [$clog2(ROB_DEPTH)-1:0] wb_rob_id,
    output ooo_pkg::word_t               wb_value
);
    import ooo_pkg::*;

    localparam int PRW = $clog2(PHYS_REGS);
    localparam int RIW = $clog2(ROB_DEPTH);

    typedef logic [PRW-1:0] preg_t;
    typedef logic [RIW-1:0] rob_id_t;

    typedef struct packed {
        word_t   value;
        logic    pending;
        rob_id_t rob_id;
    } phys_entry_t;

    typedef struct packed {
        logic      valid;
        alu_op_t   op;
        imm_t      imm;
        preg_t     prd;
        preg_t     prs1;
        preg_t     prs2;
        preg_t     old_prd;
        arch_reg_t arch_rd;
        rob_id_t   rob_id;
    } renamed_op_t;

    typedef struct packed {
        logic      valid;
        preg_t     prd;
        preg_t     old_prd;
        arch_reg_t arch_rd;
        rob_id_t   rob_id;
        word_t     value;
    } cdb_t;

    typedef struct packed {
        preg_t prs1;
        preg_t prs2;
    } rd_req_t;

    renamed_op_t       rop;
    cdb_t              cdb;
    logic              ren_we;
    preg_t             ren_prd;
    rob_id_t           ren_rob_id;
    rd_req_t           rd_req;
    phys_entry_t [1:0] rd_data;

    rename_stage #(
        .PHYS_REGS (PHYS_REGS),
        .ROB_DEPTH (ROB_DEPTH)
    ) rename_stage_inst (
        .clk           (clk),
        .rst           (rst),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .cdb           (cdb),
        .rop           (rop),
        .ren_we        (ren_we),
        .ren_prd       (ren_prd),
        .ren_rob_id    (ren_rob_id),
        .credit_return (credit_return)
    );

    phys_reg_file #(
        .PHYS_REGS (PHYS_REGS),
        .ROB_DEPTH (ROB_DEPTH)
    ) phys_reg_file_inst (
        .clk        (clk),
        .rst        (rst),
        .ren_we     (ren_we),
        .ren_prd    (ren_prd),
        .ren_rob_id (ren_rob_id),
        .cdb        (cdb),
        .rd_req     (rd_req),
        .rd_data    (rd_data)
    );

    alu_pipe #(
        .PHYS_REGS (PHYS_REGS),
        .ROB_DEPTH (ROB_DEPTH)
    ) alu_pipe_inst (
        .clk     (clk),
        .rst     (rst),
        .rop     (rop),
        .rd_req  (rd_req),
        .rd_data (rd_data),
        .cdb     (cdb)
    );

    // completion report straight off the cdb
    assign wb_valid   = cdb.valid;
    assign wb_arch_rd = cdb.arch_rd;
    assign wb_rob_id  = cdb.rob_id;
    assign wb_value   = cdb.value;

endmodule

/* tb/rename_core_chk.sv */
`timescale 1ns/1ns
/* bound into rename_stage and phys_reg_file
   ports that a bind site has no use for are tied to idle constants */
module rename_core_chk #(
    parameter int PRW = 6
) (
    input logic           clk,
    input logic           rst,
    input logic [1:0]     rd_pending,
    input logic [PRW-1:0] rd_prs1,
    input logic [PRW-1:0] rd_prs2,
    input logic           cdb_valid,
    input logic [PRW-1:0] cdb_prd,
    input logic           fl_empty,
    input logic           fl_pop,
    input logic           inst_valid,
    input logic           credit_return
);

    // a pending source is only legal while its producer sits on the cdb
    a_rs1_ready: assert property (@(posedge clk) disable iff (rst)
        rd_pending[0] |-> (cdb_valid && cdb_prd == rd_prs1))
        else $error("rs1 read a pending entry with no cdb bypass");

    a_rs2_ready: assert property (@(posedge clk) disable iff (rst)
        rd_pending[1] |-> (cdb_valid && cdb_prd == rd_prs2))
        else $error("rs2 read a pending entry with no cdb bypass");

    a_fl_underflow: assert property (@(posedge clk) disable iff (rst)
        fl_pop |-> !fl_empty)
        else $error("free list popped while empty");

    // a credit belongs to an instruction accepted two edges earlier
    a_credit_issue: assert property (@(posedge clk) disable iff (rst)
        credit_return |-> $past(inst_valid, 2))
        else $error("credit returned with no instruction two cycles before");

endmodule

// read side of the register file
bind phys_reg_file rename_core_chk #(.PRW(PRW)) prf_chk_inst (
    .clk           (clk),
    .rst           (rst),
    .rd_pending    ({rd_data[1].pending, rd_data[0].pending}),
    .rd_prs1       (rd_req.prs1),
    .rd_prs2       (rd_req.prs2),
    .cdb_valid     (cdb.valid),
    .cdb_prd       (cdb.prd),
    .fl_empty      (1'b0),
    .fl_pop        (1'b0),
    .inst_valid    (1'b0),
    .credit_return (1'b0)
);

// free list and credit side of rename
bind rename_stage rename_core_chk #(.PRW(PRW)) ren_chk_inst (
    .clk           (clk),
    .rst           (rst),
    .rd_pending    (2'b00),
    .rd_prs1       ('0),
    .rd_prs2       ('0),
    .cdb_valid     (cdb.valid),
    .cdb_prd       (cdb.prd),
    .fl_empty      (fl_count == '0),
    .fl_pop        (fl_pop),
    .inst_valid    (inst_valid),
    .credit_return (credit_return)
);

/* tb/rename_core_tb.sv */
`timescale 1ns/1ns
/* in-order reference model with completions compared in order of issue
   table runs three passes with a reset before the last one */
module rename_core_tb;
    import ooo_pkg::*;

    localparam int PHYS_REGS = 64;
    localparam int ROB_DEPTH = 8;
    localparam int TABLE_LEN = 24;
    localparam int NUM_PASSES = 3;
    // reset lands in front of this pass
    localparam int RESET_PASS = 2;
    localparam int CREDITS_INIT = PHYS_REGS - NUM_ARCH_REGS;
    // at most one idle cycle per instruction plus reset and drain slack
    localparam int CYCLE_LIMIT = NUM_PASSES * 2 * TABLE_LEN + 50;

    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_id_t;

    // one expected completion
    typedef struct packed {
        arch_reg_t rd;
        rob_id_t   rob_id;
        word_t     value;
    } expect_t;

    logic      clk;
    logic      rst;
    logic      inst_valid;
    inst_t     inst;
    logic      credit_return;
    logic      wb_valid;
    arch_reg_t wb_arch_rd;
    rob_id_t   wb_rob_id;
    word_t     wb_value;

    inst_t   stim [TABLE_LEN];
    word_t   arch_regs [NUM_ARCH_REGS];
    expect_t exp_q [$];
    integer  seed;
    int      id_ctr;
    int      sent;
    int      returned;
    int      cycles;
    int      checks;
    int      mismatches;
    int      other_errors;

    rename_core_top #(
        .PHYS_REGS (PHYS_REGS),
        .ROB_DEPTH (ROB_DEPTH)
    ) rename_core_top_inst (
        .clk           (clk),
        .rst           (rst),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .credit_return (credit_return),
        .wb_valid      (wb_valid),
        .wb_arch_rd    (wb_arch_rd),
        .wb_rob_id     (wb_rob_id),
        .wb_value      (wb_value)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic inst_t make_inst(alu_op_t op, arch_reg_t rd, arch_reg_t rs1,
                                        arch_reg_t rs2, imm_t imm);
        return '{op, rd, rs1, rs2, imm};
    endfunction

    // reference alu straight from the rv32i definitions
    function automatic word_t model_alu(alu_op_t op, word_t a, word_t b, imm_t imm);
        word_t imm_ext;
        imm_ext = {{(32 - 12){imm[11]}}, imm};
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_ADDI: return a + imm_ext;
            // only the low 5 bits of rs2 count
            ALU_SLL:  return a << b[4:0];
            default:  return '0;
        endcase
    endfunction

    task automatic fill_table();
        // independent addi where entry 0 reads x23 which is only written at the end
        stim[0]  = make_inst(ALU_ADDI, 5'd1,  5'd23, 5'd0,  12'h005);
        stim[1]  = make_inst(ALU_ADDI, 5'd2,  5'd0,  5'd0,  12'hffd);
        stim[2]  = make_inst(ALU_ADDI, 5'd3,  5'd0,  5'd0,  12'h7ff);
        stim[3]  = make_inst(ALU_ADDI, 5'd4,  5'd0,  5'd0,  12'h800);
        // dependent chain on x5 that needs the cdb bypass when back to back
        stim[4]  = make_inst(ALU_ADD,  5'd5,  5'd1,  5'd2,  12'h000);
        stim[5]  = make_inst(ALU_ADD,  5'd5,  5'd5,  5'd3,  12'h000);
        stim[6]  = make_inst(ALU_ADD,  5'd5,  5'd5,  5'd5,  12'h000);
        stim[7]  = make_inst(ALU_ADDI, 5'd6,  5'd5,  5'd0,  12'h001);
        // every op including shifts with wide rs2 fields
        stim[8]  = make_inst(ALU_SUB,  5'd7,  5'd2,  5'd1,  12'h000);
        stim[9]  = make_inst(ALU_AND,  5'd8,  5'd3,  5'd4,  12'h000);
        stim[10] = make_inst(ALU_OR,   5'd9,  5'd3,  5'd4,  12'h000);
        stim[11] = make_inst(ALU_XOR,  5'd10, 5'd9,  5'd2,  12'h000);
        stim[12] = make_inst(ALU_ADDI, 5'd11, 5'd0,  5'd0,  12'h123);
        stim[13] = make_inst(ALU_ADDI, 5'd12, 5'd0,  5'd0,  12'h7e4);
        stim[14] = make_inst(ALU_SLL,  5'd13, 5'd11, 5'd12, 12'h000);
        stim[15] = make_inst(ALU_SLL,  5'd14, 5'd3,  5'd2,  12'h000);
        // writes to x0 complete but leave it zero
        stim[16] = make_inst(ALU_ADDI, 5'd0,  5'd1,  5'd0,  12'h055);
        stim[17] = make_inst(ALU_ADD,  5'd15, 5'd0,  5'd1,  12'h000);
        stim[18] = make_inst(ALU_SUB,  5'd0,  5'd5,  5'd6,  12'h000);
        stim[19] = make_inst(ALU_OR,   5'd16, 5'd0,  5'd0,  12'h000);
        // repeated overwrites keep the free list cycling
        stim[20] = make_inst(ALU_ADDI, 5'd1,  5'd1,  5'd0,  12'h001);
        stim[21] = make_inst(ALU_ADD,  5'd1,  5'd1,  5'd1,  12'h000);
        stim[22] = make_inst(ALU_ADDI, 5'd2,  5'd1,  5'd0,  12'hfff);
        stim[23] = make_inst(ALU_XOR,  5'd23, 5'd2,  5'd1,  12'h000);
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_arch(string name, arch_reg_t got, arch_reg_t exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_rob_id(string name, rob_id_t got, rob_id_t exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    // registered outputs are stable at the falling edge
    task automatic collect_outputs();
        expect_t e;
        if (credit_return === 1'b1) begin
            returned++;
        end
        if (wb_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("completion arrived with no instruction outstanding");
                other_errors++;
            end else begin
                e = exp_q.pop_front();
                check_arch("wb_arch_rd", wb_arch_rd, e.rd);
                check_rob_id("wb_rob_id", wb_rob_id, e.rob_id);
                check_word("wb_value", wb_value, e.value);
            end
        end
    endtask

    // advance to the falling edge and sample before the caller drives
    task automatic tick();
        @(negedge clk);
        if (!rst) begin
            collect_outputs();
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (arch_regs[r]) begin
            arch_regs[r] = '0;
        end
        id_ctr = 0;
        sent = 0;
        returned = 0;
    endtask

    task automatic send_inst(inst_t i);
        expect_t e;
        // hold off while the sender has no credit
        while (CREDITS_INIT - sent + returned <= 0) begin
            tick();
        end
        e.rd = i.rd;
        e.rob_id = rob_id_t'(id_ctr);
        e.value = model_alu(i.op, arch_regs[i.rs1], arch_regs[i.rs2], i.imm);
        if (i.rd != '0) begin
            arch_regs[i.rd] = e.value;
        end
        id_ctr = (id_ctr + 1) % ROB_DEPTH;
        exp_q.push_back(e);
        sent++;
        inst_valid = 1'b1;
        inst = i;
        tick();
        inst_valid = 1'b0;
        inst = '0;
    endtask

    task automatic drain_and_check_credits();
        while (exp_q.size() != 0) begin
            tick();
        end
        if (returned != sent) begin
            $display("credits returned (%0d) differ from instructions sent (%0d)",
                     returned, sent);
            other_errors++;
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d completions missing",
                 cycles, exp_q.size());
        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errors);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int gap;
        seed = 67773;
        checks = 0;
        mismatches = 0;
        other_errors = 0;
        rst = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        fill_table();
        apply_reset();
        for (int pass = 0; pass < NUM_PASSES; pass++) begin
            if (pass == RESET_PASS) begin
                drain_and_check_credits();
                apply_reset();
            end
            for (int k = 0; k < TABLE_LEN; k++) begin
                send_inst(stim[k]);
                gap = $random(seed) & 1;
                repeat (gap) tick();
            end
        end
        drain_and_check_credits();
        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* all.f */
rtl/ooo_pkg.sv
rtl/rename_stage.sv
rtl/phys_reg_file.sv
rtl/alu_pipe.sv
rtl/rename_core_top.sv
tb/rename_core_chk.sv
tb/rename_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the rename slice testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module rename_core_tb \
    -f all.f -o rename_core_sim
./obj_dir/rename_core_sim 2>&1 | tee sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"
